// File: Makefile
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sim.f --top-module vc_rx_tb \
		--Mdir $(OBJ_DIR) -o vc_rx_sim
	./$(OBJ_DIR)/vc_rx_sim

clean:
	rm -rf $(OBJ_DIR)

// File: sim.f
vc_pkg.sv
vc_pipe_stage.sv
vc_demux.sv
vc_packet_writer.sv
vc_mem_arbiter.sv
vc_packet_buffer.sv
vc_rx_top.sv
vc_rx_tb.sv

// File: vc_demux.sv
/*
 * Buffered two-way stream demultiplexer
 * Registers beat and channel bit, then steers into one of two output stages
 */

`timescale 1ns/10ps

module vc_demux (
   input  logic              clk,
   input  logic              reset_n,
   input  vc_pkg::vc_beat_t  in_beat,
   input  logic              in_channel,
   input  logic              in_valid,
   output logic              in_ready,
   output vc_pkg::vc_beat_t  ch0_beat,
   output logic              ch0_valid,
   input  logic              ch0_ready,
   output vc_pkg::vc_beat_t  ch1_beat,
   output logic              ch1_valid,
   input  logic              ch1_ready
);

   import vc_pkg::*;

   // Registered beat with its channel
   logic     mid_valid;
   logic     mid_ready;
   logic     mid_channel;
   vc_beat_t mid_beat;

   // Output stage handshakes
   logic     rhs0_valid;
   logic     rhs0_ready;
   logic     rhs1_valid;
   logic     rhs1_ready;

   // --------------------------------------------------
   // Input stage for beat plus channel bit
   // --------------------------------------------------
   vc_pipe_stage #(
      .payload_width (VC_BEAT_WIDTH + 1)
   ) u_in_stage (
      .clk         (clk),
      .reset_n     (reset_n),
      .in_valid    (in_valid),
      .in_ready    (in_ready),
      .in_payload  ({in_channel, in_beat}),
      .out_ready   (mid_ready),
      .out_valid   (mid_valid),
      .out_payload ({mid_channel, mid_beat})
   );

   // --------------------------------------------------
   // Steering
   // --------------------------------------------------
   always_comb begin
      rhs0_valid = 1'b0;
      rhs1_valid = 1'b0;
      if (mid_channel) begin
         rhs1_valid = mid_valid;
         mid_ready  = rhs1_ready;
      end else begin
         rhs0_valid = mid_valid;
         mid_ready  = rhs0_ready;
      end
   end

   // Output stage per channel
   vc_pipe_stage #(
      .payload_width (VC_BEAT_WIDTH)
   ) u_out0_stage (
      .clk         (clk),
      .reset_n     (reset_n),
      .in_valid    (rhs0_valid),
      .in_ready    (rhs0_ready),
      .in_payload  (mid_beat),
      .out_ready   (ch0_ready),
      .out_valid   (ch0_valid),
      .out_payload (ch0_beat)
   );

   vc_pipe_stage #(
      .payload_width (VC_BEAT_WIDTH)
   ) u_out1_stage (
      .clk         (clk),
      .reset_n     (reset_n),
      .in_valid    (rhs1_valid),
      .in_ready    (rhs1_ready),
      .in_payload  (mid_beat),
      .out_ready   (ch1_ready),
      .out_valid   (ch1_valid),
      .out_payload (ch1_beat)
   );

   // A beat leaving the input stage shows up on its own channel output
   a_one_side : assert property (
      @(posedge clk) disable iff (!reset_n)
      mid_valid && mid_ready |=>
         ($past(mid_channel) ?
            (ch1_valid && ch1_beat == $past(mid_beat)) :
            (ch0_valid && ch0_beat == $past(mid_beat)))
   );

endmodule

// File: vc_mem_arbiter.sv
/*
 * Round-robin arbiter for the buffer write port
 * Two writers, one grant per cycle
 */

`timescale 1ns/10ps

module vc_mem_arbiter (
   input  logic                clk,
   input  logic                reset_n,
   input  logic                req0,
   input  logic                req1,
   input  vc_pkg::vc_mem_req_t req_data0,
   input  vc_pkg::vc_mem_req_t req_data1,
   output logic                gnt0,
   output logic                gnt1,
   output logic                wr_en,
   output vc_pkg::vc_mem_req_t wr_req
);

   // Set when writer 1 won the last grant
   logic last_gnt1;

   // --------------------------------------------------
   // Grant decode
   // --------------------------------------------------
   // On contention the side not served last wins
   assign gnt0 = req0 && (!req1 || last_gnt1);
   assign gnt1 = req1 && (!req0 || !last_gnt1);

   assign wr_en  = gnt0 || gnt1;
   assign wr_req = gnt1 ? req_data1 : req_data0;

   // Last grant register reset to favor channel 0
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         last_gnt1 <= 1'b1;
      end else if (wr_en) begin
         last_gnt1 <= gnt1;
      end
   end

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------
   a_one_hot : assert property (
      @(posedge clk) disable iff (!reset_n)
      !(gnt0 && gnt1)
   );

   // A held request waits at most one cycle
   a_wait0 : assert property (
      @(posedge clk) disable iff (!reset_n)
      req0 && !gnt0 |=> gnt0
   );

   a_wait1 : assert property (
      @(posedge clk) disable iff (!reset_n)
      req1 && !gnt1 |=> gnt1
   );

endmodule

// File: vc_packet_buffer.sv
/*
 * Packet buffer memory, 64 words
 * One arbitrated write port, one registered read port
 */

`timescale 1ns/10ps

module vc_packet_buffer (
   input  logic                 clk,
   input  logic                 wr_en,
   input  vc_pkg::vc_mem_req_t  wr_req,
   input  vc_pkg::vc_addr_t     rd_addr,
   output vc_pkg::vc_mem_word_t rd_data
);

   import vc_pkg::*;

   // Region 0 in the low half and region 1 in the high half
   vc_mem_word_t mem [VC_BUF_DEPTH];

   // --------------------------------------------------
   // Write port
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_req.addr] <= wr_req.word;
      end
   end

   // Read port with data one cycle after the address
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// File: vc_packet_writer.sv
/*
 * Per-channel packet writer
 * Holds one beat, requests a buffer write, walks the ring, counts packets
 */

`timescale 1ns/10ps

module vc_packet_writer (
   input  logic                  clk,
   input  logic                  reset_n,
   input  vc_pkg::vc_beat_t      beat,
   input  logic                  valid,
   output logic                  ready,
   input  logic                  region,
   output logic                  req,
   output vc_pkg::vc_mem_req_t   req_data,
   input  logic                  gnt,
   output vc_pkg::vc_pkt_count_t pkt_count
);

   import vc_pkg::*;

   vc_writer_state_t state;
   vc_ring_ptr_t     ring_ptr;
   // Beat waiting for its write, in stored form
   vc_mem_word_t     held_word;
   logic             accept;

   // --------------------------------------------------
   // Handshake
   // --------------------------------------------------
   // Free again in the grant cycle so back-to-back beats need no bubble
   assign ready  = (state == IDLE) || gnt;
   assign accept = valid && ready;

   assign req           = (state == PENDING);
   assign req_data.addr = {region, ring_ptr};
   assign req_data.word = held_word;

   // --------------------------------------------------
   // FSM
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: begin
               if (accept) begin
                  state <= PENDING;
               end
            end
            PENDING: begin
               // Stay pending when a new beat follows the granted one
               if (gnt && !accept) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Held beat with only the stored fields
   always_ff @(posedge clk) begin
      if (accept) begin
         held_word.data <= beat.data;
         held_word.be   <= beat.be;
         held_word.sop  <= beat.sop;
         held_word.eop  <= beat.eop;
      end
   end

   // --------------------------------------------------
   // Ring pointer and packet counter
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         ring_ptr  <= '0;
         pkt_count <= '0;
      end else if (req && gnt) begin
         // Wraps at the ring depth through the pointer width
         ring_ptr <= ring_ptr + 1'b1;
         if (held_word.eop) begin
            pkt_count <= pkt_count + 1'b1;
         end
      end
   end

   // Pending request and its address and word are held until served
   a_req_held : assert property (
      @(posedge clk) disable iff (!reset_n)
      req && !gnt |=> req && $stable(req_data)
   );

endmodule

// File: vc_pipe_stage.sv
/*
 * Single buffered valid/ready register stage
 * Holds one payload until the consumer takes it
 */

`timescale 1ns/10ps

module vc_pipe_stage #(
   parameter int payload_width = 8
) (
   input  logic                     clk,
   input  logic                     reset_n,
   input  logic                     in_valid,
   output logic                     in_ready,
   input  logic [payload_width-1:0] in_payload,
   input  logic                     out_ready,
   output logic                     out_valid,
   output logic [payload_width-1:0] out_payload
);

   logic take_in;

   // Room when empty or when the held word leaves this cycle
   assign in_ready = out_ready || !out_valid;
   assign take_in  = in_valid && in_ready;

   // --------------------------------------------------
   // Occupancy flag
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         out_valid <= 1'b0;
      end else if (take_in) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         // Taken with nothing new behind it
         out_valid <= 1'b0;
      end
   end

   // Payload register
   always_ff @(posedge clk) begin
      if (take_in) begin
         out_payload <= in_payload;
      end
   end

   // Stalled output must hold its word
   a_hold_stable : assert property (
      @(posedge clk) disable iff (!reset_n)
      out_valid && !out_ready |=> out_valid && $stable(out_payload)
   );

endmodule

// File: vc_pkg.sv
/*
 * Receive path shared definitions
 * Widths, ring geometry, beat and buffer word layouts, writer FSM states
 */

package vc_pkg;

   // --------------------------------------------------
   // Stream widths
   // --------------------------------------------------
   localparam int VC_DATA_WIDTH   = 128;
   localparam int VC_BE_WIDTH     = 16;
   localparam int VC_BARDEC_WIDTH = 8;

   // --------------------------------------------------
   // Buffer geometry
   // --------------------------------------------------
   // Words per channel ring
   localparam int VC_REGION_DEPTH    = 32;
   localparam int VC_PTR_WIDTH       = $clog2(VC_REGION_DEPTH);
   // One region per channel with the channel in the top address bit
   localparam int VC_ADDR_WIDTH      = VC_PTR_WIDTH + 1;
   localparam int VC_BUF_DEPTH       = 2 * VC_REGION_DEPTH;
   localparam int VC_PKT_COUNT_WIDTH = 16;

   typedef logic [VC_DATA_WIDTH-1:0]      vc_data_t;
   typedef logic [VC_BE_WIDTH-1:0]        vc_be_t;
   typedef logic [VC_BARDEC_WIDTH-1:0]    vc_bardec_t;
   typedef logic [VC_PTR_WIDTH-1:0]       vc_ring_ptr_t;
   typedef logic [VC_ADDR_WIDTH-1:0]      vc_addr_t;
   typedef logic [VC_PKT_COUNT_WIDTH-1:0] vc_pkt_count_t;

   // One Avalon-ST beat of 155 bits in link side bit order
   typedef struct packed {
      vc_data_t   data;
      logic       empty;
      logic       eop;
      logic       sop;
      vc_bardec_t bardec;
      vc_be_t     be;
   } vc_beat_t;

   localparam int VC_BEAT_WIDTH = $bits(vc_beat_t);

   // Stored word without bardec and empty
   typedef struct packed {
      vc_data_t data;
      vc_be_t   be;
      logic     sop;
      logic     eop;
   } vc_mem_word_t;

   // Write request from a packet writer
   typedef struct packed {
      vc_addr_t     addr;
      vc_mem_word_t word;
   } vc_mem_req_t;

   typedef enum logic {
      IDLE,
      PENDING
   } vc_writer_state_t;

endpackage

// File: vc_rx_tb.sv
/*
 * Testbench for the two-channel receive path
 * Seeded random packets, per-channel ring model, buffer readback checks
 */

`timescale 1ns/10ps

module vc_rx_tb;

   import vc_pkg::*;

   localparam int BEAT_TIMEOUT  = 200;
   localparam int COUNT_TIMEOUT = 2000;

   logic                  clk;
   logic                  reset_n;
   logic                  in_valid;
   logic                  in_ready;
   logic                  in_channel;
   vc_beat_t              in_beat;
   vc_addr_t              rd_addr;
   vc_mem_word_t          rd_data;
   vc_pkt_count_t         ch0_pkt_count;
   vc_pkt_count_t         ch1_pkt_count;

   integer                seed;

   // Model of arrival order per channel and the ring address of each word
   vc_mem_word_t          exp_word0 [$];
   vc_mem_word_t          exp_word1 [$];
   vc_addr_t              exp_addr0 [$];
   vc_addr_t              exp_addr1 [$];
   vc_ring_ptr_t          model_ptr [2];
   vc_pkt_count_t         eop_count [2];

   vc_rx_top uut (
      .clk           (clk),
      .reset_n       (reset_n),
      .in_valid      (in_valid),
      .in_ready      (in_ready),
      .in_channel    (in_channel),
      .in_beat       (in_beat),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data),
      .ch0_pkt_count (ch0_pkt_count),
      .ch1_pkt_count (ch1_pkt_count)
   );

   always #4 clk = ~clk;

   task automatic stop_run(input string what);
      $display("%s", what);
      $display("tests failed");
      $fatal(1);
   endtask

   // --------------------------------------------------
   // Reference model fed by accepted input beats
   // --------------------------------------------------
   always @(posedge clk) begin
      vc_mem_word_t word;
      if (reset_n && in_valid && in_ready) begin
         word.data = in_beat.data;
         word.be   = in_beat.be;
         word.sop  = in_beat.sop;
         word.eop  = in_beat.eop;
         if (in_channel) begin
            exp_word1.push_back(word);
            exp_addr1.push_back({1'b1, model_ptr[1]});
         end else begin
            exp_word0.push_back(word);
            exp_addr0.push_back({1'b0, model_ptr[0]});
         end
         model_ptr[in_channel] = model_ptr[in_channel] + 1'b1;
         if (in_beat.eop) begin
            eop_count[in_channel] = eop_count[in_channel] + 1'b1;
         end
      end
   end

   // A counter can never run ahead of the accepted end-of-packet beats
   a_count_bound : assert property (
      @(posedge clk) disable iff (!reset_n)
      (ch0_pkt_count <= eop_count[0]) && (ch1_pkt_count <= eop_count[1])
   ) else stop_run($sformatf("Fail %0t ns: packet counter ahead of model (%0d/%0d, %0d/%0d)",
                             $time, ch0_pkt_count, eop_count[0],
                             ch1_pkt_count, eop_count[1]));

   // --------------------------------------------------
   // Stimulus helpers called on a falling edge
   // --------------------------------------------------
   task automatic make_beat(input logic sop, input logic eop, output vc_beat_t b);
      logic [31:0] r;
      r        = $random(seed);
      b.data   = {$random(seed), $random(seed), $random(seed), $random(seed)};
      b.be     = r[15:0];
      b.bardec = r[23:16];
      b.empty  = r[24];
      b.sop    = sop;
      b.eop    = eop;
   endtask

   // Hold the beat until in_ready is seen and transfer on the next rising edge
   task automatic send_beat(input logic ch, input vc_beat_t b);
      int waited;
      waited     = 0;
      in_channel = ch;
      in_beat    = b;
      in_valid   = 1'b1;
      while (!in_ready) begin
         @(negedge clk);
         waited++;
         if (waited > BEAT_TIMEOUT) begin
            stop_run("input stream never became ready");
         end
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic send_packet(input logic ch, input bit with_gaps);
      logic [31:0] r;
      int          len;
      vc_beat_t    b;
      r   = $random(seed);
      len = int'(r[1:0]) + 1;
      for (int i = 0; i < len; i++) begin
         make_beat(i == 0, i == len - 1, b);
         send_beat(ch, b);
         if (with_gaps) begin
            r = $random(seed);
            repeat (int'(r[1:0])) @(negedge clk);
         end
      end
   endtask

   // Back-to-back beats on a random channel per beat
   // Open packets are closed at the end
   task automatic send_interleaved(input int n_beats);
      logic [31:0] r;
      int          left [2];
      int          len [2];
      int          ch;
      vc_beat_t    b;
      left[0] = 0;
      left[1] = 0;
      len[0]  = 0;
      len[1]  = 0;
      for (int k = 0; k < n_beats || left[0] != 0 || left[1] != 0; k++) begin
         r  = $random(seed);
         ch = (k < n_beats) ? int'(r[4]) : ((left[0] != 0) ? 0 : 1);
         if (left[ch] == 0) begin
            len[ch]  = int'(r[1:0]) + 1;
            left[ch] = len[ch];
         end
         make_beat(left[ch] == len[ch], left[ch] == 1, b);
         send_beat(ch[0], b);
         left[ch]--;
      end
   endtask

   // --------------------------------------------------
   // Readback and checks
   // --------------------------------------------------
   task automatic wait_count(input logic ch);
      int waited;
      waited = 0;
      while ((ch ? ch1_pkt_count : ch0_pkt_count) != eop_count[ch]) begin
         @(negedge clk);
         waited++;
         if (waited > COUNT_TIMEOUT) begin
            stop_run($sformatf("channel %0d packet counter never reached %0d",
                               ch, eop_count[ch]));
         end
      end
   endtask

   // Registered read with data one cycle after the address
   task automatic read_word(input vc_addr_t addr, output vc_mem_word_t word);
      @(negedge clk);
      rd_addr = addr;
      @(negedge clk);
      word = rd_data;
   endtask

   // Newest ring depth worth of words must sit where the model put them
   task automatic check_ring(input logic ch);
      int           n;
      int           first;
      vc_mem_word_t want;
      vc_mem_word_t got;
      vc_addr_t     addr;
      n     = ch ? exp_word1.size() : exp_word0.size();
      first = (n > VC_REGION_DEPTH) ? n - VC_REGION_DEPTH : 0;
      for (int j = first; j < n; j++) begin
         want = ch ? exp_word1[j] : exp_word0[j];
         addr = ch ? exp_addr1[j] : exp_addr0[j];
         read_word(addr, got);
         assert (got == want) else
            stop_run($sformatf("Fail %0t ns: ch%0d addr %0d got %h/%h/%b/%b want %h/%h/%b/%b",
                               $time, ch, addr, got.data, got.be, got.sop, got.eop,
                               want.data, want.be, want.sop, want.eop));
      end
   endtask

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial begin
      int base;
      clk          = 1'b0;
      reset_n      = 1'b0;
      in_valid     = 1'b0;
      in_channel   = 1'b0;
      in_beat      = '0;
      rd_addr      = '0;
      seed         = 32'ha949_12f6;
      model_ptr[0] = '0;
      model_ptr[1] = '0;
      eop_count[0] = '0;
      eop_count[1] = '0;

      repeat (3) @(negedge clk);
      reset_n = 1'b1;
      @(negedge clk);

      // Reset state
      assert (in_ready && ch0_pkt_count == 0 && ch1_pkt_count == 0) else
         stop_run($sformatf("Fail %0t ns: bad state after reset", $time));

      // Single packet per channel
      // Channel 1 must leave region 0 untouched
      send_packet(1'b0, 1'b1);
      wait_count(1'b0);
      check_ring(1'b0);
      send_packet(1'b1, 1'b1);
      wait_count(1'b1);
      check_ring(1'b1);
      check_ring(1'b0);

      // Contending writers
      send_interleaved(120);
      wait_count(1'b0);
      wait_count(1'b1);
      check_ring(1'b0);
      check_ring(1'b1);

      // Ring wrap on channel 0
      base = exp_word0.size();
      while (exp_word0.size() < base + VC_REGION_DEPTH + 1) begin
         send_packet(1'b0, 1'b1);
      end
      wait_count(1'b0);
      check_ring(1'b0);
      check_ring(1'b1);

      $display("all tests passed");
      $finish;
   end

endmodule

// File: vc_rx_top.sv
/*
 * Two-channel receive path top level
 * Demux, per-channel writers, write arbiter and shared packet buffer
 */

`timescale 1ns/10ps

module vc_rx_top (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  in_valid,
   output logic                  in_ready,
   input  logic                  in_channel,
   input  vc_pkg::vc_beat_t      in_beat,
   input  vc_pkg::vc_addr_t      rd_addr,
   output vc_pkg::vc_mem_word_t  rd_data,
   output vc_pkg::vc_pkt_count_t ch0_pkt_count,
   output vc_pkg::vc_pkt_count_t ch1_pkt_count
);

   import vc_pkg::*;

   // Demux to writers
   vc_beat_t    ch0_beat;
   logic        ch0_valid;
   logic        ch0_ready;
   vc_beat_t    ch1_beat;
   logic        ch1_valid;
   logic        ch1_ready;

   // Writers to arbiter
   logic        req0;
   logic        req1;
   logic        gnt0;
   logic        gnt1;
   vc_mem_req_t req_data0;
   vc_mem_req_t req_data1;

   // Arbiter to buffer
   logic        wr_en;
   vc_mem_req_t wr_req;

   // --------------------------------------------------
   // Stream side
   // --------------------------------------------------
   vc_demux u_demux (
      .clk        (clk),
      .reset_n    (reset_n),
      .in_beat    (in_beat),
      .in_channel (in_channel),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .ch0_beat   (ch0_beat),
      .ch0_valid  (ch0_valid),
      .ch0_ready  (ch0_ready),
      .ch1_beat   (ch1_beat),
      .ch1_valid  (ch1_valid),
      .ch1_ready  (ch1_ready)
   );

   // Channel 0 writes the low region
   vc_packet_writer u_writer0 (
      .clk       (clk),
      .reset_n   (reset_n),
      .beat      (ch0_beat),
      .valid     (ch0_valid),
      .ready     (ch0_ready),
      .region    (1'b0),
      .req       (req0),
      .req_data  (req_data0),
      .gnt       (gnt0),
      .pkt_count (ch0_pkt_count)
   );

   // Channel 1 writes the high region
   vc_packet_writer u_writer1 (
      .clk       (clk),
      .reset_n   (reset_n),
      .beat      (ch1_beat),
      .valid     (ch1_valid),
      .ready     (ch1_ready),
      .region    (1'b1),
      .req       (req1),
      .req_data  (req_data1),
      .gnt       (gnt1),
      .pkt_count (ch1_pkt_count)
   );

   // --------------------------------------------------
   // Memory side
   // --------------------------------------------------
   vc_mem_arbiter u_arbiter (
      .clk       (clk),
      .reset_n   (reset_n),
      .req0      (req0),
      .req1      (req1),
      .req_data0 (req_data0),
      .req_data1 (req_data1),
      .gnt0      (gnt0),
      .gnt1      (gnt1),
      .wr_en     (wr_en),
      .wr_req    (wr_req)
   );

   vc_packet_buffer u_buffer (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_req  (wr_req),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule
